// ==== rtl/ip_tx_pkg.sv ====
// IPv4 transmit framer definitions
`default_nettype none

package ip_tx_pkg;

    // datapath geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_W = DATA_BYTES * 8;
    localparam int KEEP_W = DATA_BYTES;

    localparam int IP_HDR_BYTES = 20;
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // fields in wire order, first byte at the top
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // words[9] is the first header word on the wire
    typedef union packed {
        ip_hdr_t         fields;
        logic [9:0][15:0] words;
    } ip_hdr_u;

    typedef enum logic [2:0] {
        idle, hdr_word0, hdr_word1, hdr_last, payload, hold_last, drain
    } ctrl_state_t;

    // contiguous mask from lane 0 up
    function automatic logic [3:0] keep_to_count(input logic [KEEP_W-1:0] keep);
        logic [3:0] count;
        count = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            if (keep[i]) count = 4'(i + 1);
        end
        return count;
    endfunction

    function automatic logic [KEEP_W-1:0] count_to_keep(input logic [3:0] count);
        logic [KEEP_W-1:0] keep;
        for (int i = 0; i < KEEP_W; i++) begin
            keep[i] = (i < count);
        end
        return keep;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/ip_hdr_capture.sv ====
// IPv4 header capture and checksum
`timescale 1ns/100ps
`default_nettype none

module ip_hdr_capture (
    input  logic               clk,
    input  logic               rst,
    input  logic               s_ip_hdr_valid,
    output logic               s_ip_hdr_ready,
    input  logic [47:0]        s_eth_dest_mac,
    input  logic [47:0]        s_eth_src_mac,
    input  logic [15:0]        s_eth_type,
    input  logic [5:0]         s_ip_dscp,
    input  logic [1:0]         s_ip_ecn,
    input  logic [15:0]        s_ip_length,
    input  logic [15:0]        s_ip_identification,
    input  logic [2:0]         s_ip_flags,
    input  logic [12:0]        s_ip_fragment_offset,
    input  logic [7:0]         s_ip_ttl,
    input  logic [7:0]         s_ip_protocol,
    input  logic [31:0]        s_ip_source_ip,
    input  logic [31:0]        s_ip_dest_ip,
    input  logic               ctrl_idle,
    output logic               hdr_start,
    output ip_tx_pkg::ip_hdr_u hdr,
    output logic               m_eth_hdr_valid,
    input  logic               m_eth_hdr_ready,
    output logic [47:0]        m_eth_dest_mac,
    output logic [47:0]        m_eth_src_mac,
    output logic [15:0]        m_eth_type
);

    ip_tx_pkg::ip_hdr_u hdr_in;
    logic [19:0] sum;
    logic [16:0] fold;
    logic [15:0] csum;
    logic        eth_valid_next;

    assign hdr_start = s_ip_hdr_valid && s_ip_hdr_ready;
    assign eth_valid_next = hdr_start || (m_eth_hdr_valid && !m_eth_hdr_ready);

    // ones' complement sum over the header with a zero checksum field
    always_comb begin
        hdr_in = '0;
        hdr_in.fields.version = ip_tx_pkg::IP_VERSION;
        hdr_in.fields.ihl = ip_tx_pkg::IP_IHL;
        hdr_in.fields.dscp = s_ip_dscp;
        hdr_in.fields.ecn = s_ip_ecn;
        hdr_in.fields.length = s_ip_length;
        hdr_in.fields.identification = s_ip_identification;
        hdr_in.fields.flags = s_ip_flags;
        hdr_in.fields.fragment_offset = s_ip_fragment_offset;
        hdr_in.fields.ttl = s_ip_ttl;
        hdr_in.fields.protocol = s_ip_protocol;
        hdr_in.fields.source_ip = s_ip_source_ip;
        hdr_in.fields.dest_ip = s_ip_dest_ip;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(hdr_in.words[i]);
        end
        // two end-around carry steps cover the worst case
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        csum = ~(fold[15:0] + 16'(fold[16]));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_ip_hdr_ready <= 1'b0;
            m_eth_hdr_valid <= 1'b0;
        end else begin
            s_ip_hdr_ready <= ctrl_idle && !eth_valid_next;
            m_eth_hdr_valid <= eth_valid_next;
        end
        if (hdr_start) begin
            hdr <= hdr_in;
            hdr.fields.checksum <= csum;
            m_eth_dest_mac <= s_eth_dest_mac;
            m_eth_src_mac <= s_eth_src_mac;
            m_eth_type <= s_eth_type;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ip_payload_align.sv ====
// payload realignment by four byte lanes
`timescale 1ns/100ps
`default_nettype none

module ip_payload_align (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ip_tx_pkg::DATA_W-1:0] s_ip_payload_tdata,
    input  logic [ip_tx_pkg::KEEP_W-1:0] s_ip_payload_tkeep,
    input  logic                         s_ip_payload_tvalid,
    output logic                         s_ip_payload_tready,
    input  logic                         s_ip_payload_tlast,
    output logic [ip_tx_pkg::DATA_W-1:0] sh_data,
    output logic [ip_tx_pkg::KEEP_W-1:0] sh_keep,
    output logic                         sh_valid,
    output logic                         sh_last,
    input  logic                         sh_take,
    input  logic                         sh_flush,
    input  logic                         take_enable
);

    logic [ip_tx_pkg::DATA_W-1:0] save_data;
    logic [ip_tx_pkg::KEEP_W-1:0] save_keep;
    // last word left bytes in the upper lanes
    logic                         extra_cycle;

    // no new input while the trailing word is still owed
    assign s_ip_payload_tready = take_enable && !extra_cycle;

    always_comb begin
        sh_data[31:0] = save_data[63:32];
        sh_keep[3:0] = save_keep[7:4];
        if (extra_cycle) begin
            sh_data[63:32] = '0;
            sh_keep[7:4] = '0;
            sh_valid = 1'b1;
            sh_last = 1'b1;
        end else begin
            sh_data[63:32] = s_ip_payload_tdata[31:0];
            sh_keep[7:4] = s_ip_payload_tkeep[3:0];
            sh_valid = s_ip_payload_tvalid;
            sh_last = s_ip_payload_tlast && (s_ip_payload_tkeep[7:4] == 4'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            extra_cycle <= 1'b0;
        end else if (sh_flush) begin
            extra_cycle <= 1'b0;
        end else if (sh_take) begin
            extra_cycle <= !extra_cycle && s_ip_payload_tlast
                           && (s_ip_payload_tkeep[7:4] != 4'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (sh_flush) begin
            save_keep <= '0;
        end else if (sh_take && !extra_cycle) begin
            save_data <= s_ip_payload_tdata;
            save_keep <= s_ip_payload_tkeep;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ip_tx_ctrl.sv ====
// frame sequencing FSM
`timescale 1ns/100ps
`default_nettype none

module ip_tx_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hdr_start,
    input  ip_tx_pkg::ip_hdr_u           hdr,
    input  logic [ip_tx_pkg::DATA_W-1:0] sh_data,
    input  logic [ip_tx_pkg::KEEP_W-1:0] sh_keep,
    input  logic                         sh_valid,
    input  logic                         sh_last,
    input  logic                         int_ready,
    output logic                         ctrl_idle,
    output logic                         busy,
    output logic                         sh_take,
    output logic                         sh_flush,
    output logic                         take_enable,
    output logic [ip_tx_pkg::DATA_W-1:0] int_data,
    output logic [ip_tx_pkg::KEEP_W-1:0] int_keep,
    output logic                         int_valid,
    output logic                         int_last,
    output logic                         int_user,
    output logic                         error_payload_early_termination
);

    // header words are big endian, lane 0 goes first
    function automatic logic [15:0] swap16(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    ip_tx_pkg::ctrl_state_t state, state_next;
    logic [15:0]                  remaining, remaining_next;
    logic [ip_tx_pkg::DATA_W-1:0] held_data, word_data;
    logic [ip_tx_pkg::KEEP_W-1:0] held_keep, word_keep, trim_keep;
    logic                         word_complete, store_held, err_next;

    assign ctrl_idle = (state == ip_tx_pkg::idle);
    assign busy = !ctrl_idle;
    assign sh_flush = ctrl_idle;

    // current payload word, first one carries the destination IP
    always_comb begin
        if (state == ip_tx_pkg::hdr_last) begin
            word_data = {sh_data[63:32], swap16(hdr.words[0]), swap16(hdr.words[1])};
            word_keep = {sh_keep[7:4], 4'hf};
        end else begin
            word_data = sh_data;
            word_keep = sh_keep;
        end
        word_complete = 16'(ip_tx_pkg::keep_to_count(word_keep)) >= remaining;
        trim_keep = word_complete ? ip_tx_pkg::count_to_keep(remaining[3:0]) : word_keep;
    end

    always_comb begin
        state_next = state;
        remaining_next = remaining;
        store_held = 1'b0;
        err_next = 1'b0;
        sh_take = 1'b0;
        take_enable = 1'b0;
        int_data = '0;
        int_keep = '0;
        int_valid = 1'b0;
        int_last = 1'b0;
        int_user = 1'b0;
        case (state)
            ip_tx_pkg::idle: begin
                if (hdr_start) state_next = ip_tx_pkg::hdr_word0;
            end
            ip_tx_pkg::hdr_word0: begin
                // bytes still owed from the last header word on
                remaining_next = hdr.fields.length - 16'(ip_tx_pkg::IP_HDR_BYTES - 4);
                int_data = {swap16(hdr.words[6]), swap16(hdr.words[7]),
                            swap16(hdr.words[8]), swap16(hdr.words[9])};
                int_keep = '1;
                if (int_ready) begin
                    int_valid = 1'b1;
                    state_next = ip_tx_pkg::hdr_word1;
                end
            end
            ip_tx_pkg::hdr_word1: begin
                int_data = {swap16(hdr.words[2]), swap16(hdr.words[3]),
                            swap16(hdr.words[4]), swap16(hdr.words[5])};
                int_keep = '1;
                if (int_ready) begin
                    int_valid = 1'b1;
                    state_next = ip_tx_pkg::hdr_last;
                end
            end
            ip_tx_pkg::hdr_last, ip_tx_pkg::payload: begin
                take_enable = int_ready;
                int_data = word_data;
                int_keep = trim_keep;
                if (int_ready && sh_valid) begin
                    sh_take = 1'b1;
                    remaining_next = remaining - 16'd8;
                    if (word_complete && sh_last) begin
                        int_valid = 1'b1;
                        int_last = 1'b1;
                        state_next = ip_tx_pkg::idle;
                    end else if (word_complete) begin
                        store_held = 1'b1;
                        state_next = ip_tx_pkg::drain;
                    end else if (sh_last) begin
                        // input ended short of the IP length
                        int_valid = 1'b1;
                        int_last = 1'b1;
                        int_user = 1'b1;
                        err_next = 1'b1;
                        state_next = ip_tx_pkg::idle;
                    end else begin
                        int_valid = 1'b1;
                        state_next = ip_tx_pkg::payload;
                    end
                end
            end
            ip_tx_pkg::drain: begin
                // discard input beyond the length
                take_enable = 1'b1;
                if (sh_valid) begin
                    sh_take = 1'b1;
                    if (sh_last) state_next = ip_tx_pkg::hold_last;
                end
            end
            ip_tx_pkg::hold_last: begin
                int_data = held_data;
                int_keep = held_keep;
                int_last = 1'b1;
                if (int_ready) begin
                    int_valid = 1'b1;
                    state_next = ip_tx_pkg::idle;
                end
            end
            default: state_next = ip_tx_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ip_tx_pkg::idle;
            error_payload_early_termination <= 1'b0;
        end else begin
            state <= state_next;
            error_payload_early_termination <= err_next;
        end
        remaining <= remaining_next;
        if (store_held) begin
            held_data <= word_data;
            held_keep <= trim_keep;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ip_skid_buffer.sv ====
// output skid buffer
`timescale 1ns/100ps
`default_nettype none

module ip_skid_buffer #(
    parameter int DATA_W = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [DATA_W-1:0]   int_data,
    input  logic [DATA_W/8-1:0] int_keep,
    input  logic                int_valid,
    output logic                int_ready,
    input  logic                int_last,
    input  logic                int_user,
    output logic [DATA_W-1:0]   m_eth_payload_tdata,
    output logic [DATA_W/8-1:0] m_eth_payload_tkeep,
    output logic                m_eth_payload_tvalid,
    input  logic                m_eth_payload_tready,
    output logic                m_eth_payload_tlast,
    output logic                m_eth_payload_tuser
);

    logic [DATA_W-1:0]   temp_data;
    logic [DATA_W/8-1:0] temp_keep;
    logic                temp_valid, temp_last, temp_user;
    logic                out_valid_next, temp_valid_next, ready_early;
    logic                load_out, load_temp, temp_to_out;

    // ready next cycle unless the temp entry could fill up
    assign ready_early = m_eth_payload_tready
                         || (!temp_valid && (!m_eth_payload_tvalid || !int_valid));

    always_comb begin
        out_valid_next = m_eth_payload_tvalid;
        temp_valid_next = temp_valid;
        load_out = 1'b0;
        load_temp = 1'b0;
        temp_to_out = 1'b0;
        if (int_ready) begin
            if (m_eth_payload_tready || !m_eth_payload_tvalid) begin
                out_valid_next = int_valid;
                load_out = 1'b1;
            end else begin
                temp_valid_next = int_valid;
                load_temp = 1'b1;
            end
        end else if (m_eth_payload_tready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_eth_payload_tvalid <= 1'b0;
            temp_valid <= 1'b0;
            int_ready <= 1'b0;
        end else begin
            m_eth_payload_tvalid <= out_valid_next;
            temp_valid <= temp_valid_next;
            int_ready <= ready_early;
        end
        if (load_out) begin
            m_eth_payload_tdata <= int_data;
            m_eth_payload_tkeep <= int_keep;
            m_eth_payload_tlast <= int_last;
        end else if (temp_to_out) begin
            m_eth_payload_tdata <= temp_data;
            m_eth_payload_tkeep <= temp_keep;
            m_eth_payload_tlast <= temp_last;
        end
        // tuser marks early termination and is low out of reset
        if (rst) begin
            m_eth_payload_tuser <= 1'b0;
        end else if (load_out) begin
            m_eth_payload_tuser <= int_user;
        end else if (temp_to_out) begin
            m_eth_payload_tuser <= temp_user;
        end
        if (load_temp) begin
            temp_data <= int_data;
            temp_keep <= int_keep;
            temp_last <= int_last;
            temp_user <= int_user;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ip_eth_tx.sv ====
// IPv4 transmit framer top level
`timescale 1ns/100ps
`default_nettype none

module ip_eth_tx #(
    parameter int DATA_W = ip_tx_pkg::DATA_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                s_ip_hdr_valid,
    output logic                s_ip_hdr_ready,
    input  logic [47:0]         s_eth_dest_mac,
    input  logic [47:0]         s_eth_src_mac,
    input  logic [15:0]         s_eth_type,
    input  logic [5:0]          s_ip_dscp,
    input  logic [1:0]          s_ip_ecn,
    input  logic [15:0]         s_ip_length,
    input  logic [15:0]         s_ip_identification,
    input  logic [2:0]          s_ip_flags,
    input  logic [12:0]         s_ip_fragment_offset,
    input  logic [7:0]          s_ip_ttl,
    input  logic [7:0]          s_ip_protocol,
    input  logic [31:0]         s_ip_source_ip,
    input  logic [31:0]         s_ip_dest_ip,
    input  logic [DATA_W-1:0]   s_ip_payload_tdata,
    input  logic [DATA_W/8-1:0] s_ip_payload_tkeep,
    input  logic                s_ip_payload_tvalid,
    output logic                s_ip_payload_tready,
    input  logic                s_ip_payload_tlast,
    output logic                m_eth_hdr_valid,
    input  logic                m_eth_hdr_ready,
    output logic [47:0]         m_eth_dest_mac,
    output logic [47:0]         m_eth_src_mac,
    output logic [15:0]         m_eth_type,
    output logic [DATA_W-1:0]   m_eth_payload_tdata,
    output logic [DATA_W/8-1:0] m_eth_payload_tkeep,
    output logic                m_eth_payload_tvalid,
    input  logic                m_eth_payload_tready,
    output logic                m_eth_payload_tlast,
    output logic                m_eth_payload_tuser,
    output logic                busy,
    output logic                error_payload_early_termination
);

    ip_tx_pkg::ip_hdr_u  hdr;
    logic                hdr_start, ctrl_idle;
    logic [DATA_W-1:0]   sh_data, int_data;
    logic [DATA_W/8-1:0] sh_keep, int_keep;
    logic                sh_valid, sh_last, sh_take, sh_flush, take_enable;
    logic                int_valid, int_ready, int_last, int_user;

    ip_hdr_capture u_hdr_capture (
        .clk, .rst, .s_ip_hdr_valid, .s_ip_hdr_ready,
        .s_eth_dest_mac, .s_eth_src_mac, .s_eth_type,
        .s_ip_dscp, .s_ip_ecn, .s_ip_length, .s_ip_identification,
        .s_ip_flags, .s_ip_fragment_offset, .s_ip_ttl, .s_ip_protocol,
        .s_ip_source_ip, .s_ip_dest_ip,
        .ctrl_idle, .hdr_start, .hdr,
        .m_eth_hdr_valid, .m_eth_hdr_ready,
        .m_eth_dest_mac, .m_eth_src_mac, .m_eth_type
    );

    ip_payload_align u_payload_align (
        .clk, .rst,
        .s_ip_payload_tdata, .s_ip_payload_tkeep, .s_ip_payload_tvalid,
        .s_ip_payload_tready, .s_ip_payload_tlast,
        .sh_data, .sh_keep, .sh_valid, .sh_last,
        .sh_take, .sh_flush, .take_enable
    );

    ip_tx_ctrl u_tx_ctrl (
        .clk, .rst, .hdr_start, .hdr,
        .sh_data, .sh_keep, .sh_valid, .sh_last, .int_ready,
        .ctrl_idle, .busy, .sh_take, .sh_flush, .take_enable,
        .int_data, .int_keep, .int_valid, .int_last, .int_user,
        .error_payload_early_termination
    );

    ip_skid_buffer #(
        .DATA_W(DATA_W)
    ) u_skid_buffer (
        .clk, .rst,
        .int_data, .int_keep, .int_valid, .int_ready, .int_last, .int_user,
        .m_eth_payload_tdata, .m_eth_payload_tkeep, .m_eth_payload_tvalid,
        .m_eth_payload_tready, .m_eth_payload_tlast, .m_eth_payload_tuser
    );

endmodule

`default_nettype wire

// ==== verif/ip_frame_model.svh ====
// IPv4 frame reference model

// header bytes in wire order, checksum filled in by build_frame
logic [7:0] hb [0:19];

// 16-bit ones' complement sum over the ten big-endian header words
function automatic logic [15:0] ones_sum(input logic [7:0] b [0:19]);
    logic [31:0] s;
    s = 0;
    for (int i = 0; i < 10; i++) begin
        s = s + {b[2*i], b[2*i+1]};
    end
    while (s[31:16] != 0) begin
        s = s[15:0] + s[31:16];
    end
    return s[15:0];
endfunction

// expected output for one frame; sent payload bytes go to pl
task automatic build_frame(input int plen, input int sent, input bit short_frame);
    int out_len;
    hb[0] = {4'd4, 4'd5};
    hb[1] = {hf_dscp, hf_ecn};
    {hb[2], hb[3]} = 16'(20 + plen);
    {hb[4], hb[5]} = hf_id;
    {hb[6], hb[7]} = {hf_flags, hf_frag};
    hb[8] = hf_ttl;
    hb[9] = hf_proto;
    {hb[10], hb[11]} = 16'h0000;
    {hb[12], hb[13], hb[14], hb[15]} = hf_src;
    {hb[16], hb[17], hb[18], hb[19]} = hf_dst;
    {hb[10], hb[11]} = ~ones_sum(hb);
    for (int i = 0; i < 20; i++) begin
        exp_bytes.push_back(hb[i]);
    end
    pl.delete();
    for (int i = 0; i < sent; i++) begin
        pl.push_back(8'($random(seed)));
    end
    // trimmed to the IP length, or cut short by the input
    out_len = (sent < plen) ? sent : plen;
    for (int i = 0; i < out_len; i++) begin
        exp_bytes.push_back(pl[i]);
    end
    exp_len.push_back(20 + out_len);
    exp_user.push_back(short_frame);
    exp_eth.push_back({hf_dmac, hf_smac, hf_type});
endtask

// ==== verif/ip_eth_tx_tb.sv ====
// IPv4 framer testbench
`timescale 1ns/100ps
`default_nettype none

module ip_eth_tx_tb;

    localparam int NUM_FRAMES = 12;
    localparam int MAX_WORDS = 16;

    logic clk = 1'b0;
    logic rst;
    logic s_ip_hdr_valid, s_ip_hdr_ready;
    logic [47:0] s_eth_dest_mac, s_eth_src_mac, m_eth_dest_mac, m_eth_src_mac;
    logic [15:0] s_eth_type, m_eth_type, s_ip_length, s_ip_identification;
    logic [5:0] s_ip_dscp;
    logic [1:0] s_ip_ecn;
    logic [2:0] s_ip_flags;
    logic [12:0] s_ip_fragment_offset;
    logic [7:0] s_ip_ttl, s_ip_protocol;
    logic [31:0] s_ip_source_ip, s_ip_dest_ip;
    logic [63:0] s_ip_payload_tdata, m_eth_payload_tdata;
    logic [7:0] s_ip_payload_tkeep, m_eth_payload_tkeep;
    logic s_ip_payload_tvalid, s_ip_payload_tready, s_ip_payload_tlast;
    logic m_eth_hdr_valid, m_eth_hdr_ready;
    logic m_eth_payload_tvalid, m_eth_payload_tready, m_eth_payload_tlast;
    logic m_eth_payload_tuser, busy, error_payload_early_termination;

    integer seed;
    int errors = 0;
    int frames_done = 0;
    int eth_done = 0;
    int err_pulses = 0;
    int short_frames = 0;
    int frame_pos = 0;
    int rem;
    bit stress = 0;
    logic [7:0] pl [$];
    logic [7:0] exp_bytes [$];
    int exp_len [$];
    bit exp_user [$];
    logic [111:0] exp_eth [$];
    logic [7:0] rx_hdr [0:19];
    logic [47:0] hf_dmac, hf_smac;
    logic [15:0] hf_type, hf_id;
    logic [5:0] hf_dscp;
    logic [1:0] hf_ecn;
    logic [2:0] hf_flags;
    logic [12:0] hf_frag;
    logic [7:0] hf_ttl, hf_proto;
    logic [31:0] hf_src, hf_dst;

    `include "ip_frame_model.svh"

    ip_eth_tx uut (.*);

    always #4 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [111:0] got,
                               input logic [111:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    assert property (@(posedge clk) rst |=> !s_ip_hdr_ready && !s_ip_payload_tready
        && !m_eth_hdr_valid && !m_eth_payload_tvalid && !busy
        && !error_payload_early_termination && !m_eth_payload_tuser)
        else flag_error("outputs not low after reset");
    assert property (@(posedge clk) disable iff (rst)
        m_eth_payload_tvalid && !m_eth_payload_tready |=> m_eth_payload_tvalid
        && $stable(m_eth_payload_tdata) && $stable(m_eth_payload_tkeep)
        && $stable(m_eth_payload_tlast) && $stable(m_eth_payload_tuser))
        else flag_error("payload output changed while stalled");
    assert property (@(posedge clk) disable iff (rst)
        m_eth_hdr_valid && !m_eth_hdr_ready |=> m_eth_hdr_valid
        && $stable(m_eth_dest_mac) && $stable(m_eth_src_mac) && $stable(m_eth_type))
        else flag_error("ethernet header changed or dropped before ready");
    assert property (@(posedge clk) disable iff (rst)
        s_ip_hdr_valid && s_ip_hdr_ready |=> busy)
        else flag_error("busy not raised after header accept");
    assert property (@(posedge clk) disable iff (rst) !(s_ip_hdr_ready && busy))
        else flag_error("header ready high while busy");
    assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination)
        else flag_error("early termination error longer than one cycle");

    // output scoreboard
    always @(posedge clk) begin
        if (!rst && m_eth_payload_tvalid && m_eth_payload_tready) begin
            rem = (exp_len.size() > 0) ? exp_len[0] - frame_pos : 0;
            for (int i = 0; i < 8; i++) begin
                if (m_eth_payload_tkeep[i]) begin
                    if (frame_pos < 20) rx_hdr[frame_pos] = m_eth_payload_tdata[8*i +: 8];
                    frame_pos++;
                    if (exp_bytes.size() == 0) begin
                        flag_error("output byte with none expected");
                    end else begin
                        check_value("m_eth_payload_tdata byte",
                                    m_eth_payload_tdata[8*i +: 8], exp_bytes.pop_front());
                    end
                end
            end
            if (m_eth_payload_tlast) begin
                if (exp_len.size() == 0) begin
                    flag_error("frame end with no frame expected");
                end else begin
                    // one lane per remaining byte, from lane 0 up
                    check_value("m_eth_payload_tkeep", m_eth_payload_tkeep,
                                8'(8'hff >> (8 - rem)));
                    check_value("frame length", frame_pos, exp_len.pop_front());
                    check_value("m_eth_payload_tuser", m_eth_payload_tuser,
                                exp_user.pop_front());
                    check_value("header ones sum", ones_sum(rx_hdr), 16'hffff);
                end
                frame_pos = 0;
                frames_done++;
            end else begin
                check_value("m_eth_payload_tkeep", m_eth_payload_tkeep, 8'hff);
                check_value("m_eth_payload_tuser", m_eth_payload_tuser, 1'b0);
            end
        end
        if (!rst && m_eth_hdr_valid && m_eth_hdr_ready) begin
            if (exp_eth.size() == 0) begin
                flag_error("ethernet header with none expected");
            end else begin
                check_value("m_eth_hdr fields",
                            {m_eth_dest_mac, m_eth_src_mac, m_eth_type}, exp_eth.pop_front());
            end
            eth_done++;
        end
        if (!rst && error_payload_early_termination) err_pulses++;
    end

    // sink readies are random only in the stress frames
    always @(posedge clk) begin
        if (stress) begin
            m_eth_payload_tready <= ({$random(seed)} % 3) != 0;
            m_eth_hdr_ready <= {$random(seed)} % 2;
        end else begin
            m_eth_payload_tready <= 1'b1;
            m_eth_hdr_ready <= 1'b1;
        end
    end

    task automatic send_header();
        if (stress) repeat ({$random(seed)} % 3) @(posedge clk);
        @(posedge clk);
        s_ip_hdr_valid <= 1'b1;
        s_eth_dest_mac <= hf_dmac;
        s_eth_src_mac <= hf_smac;
        s_eth_type <= hf_type;
        s_ip_dscp <= hf_dscp;
        s_ip_ecn <= hf_ecn;
        s_ip_length <= {hb[2], hb[3]};
        s_ip_identification <= hf_id;
        s_ip_flags <= hf_flags;
        s_ip_fragment_offset <= hf_frag;
        s_ip_ttl <= hf_ttl;
        s_ip_protocol <= hf_proto;
        s_ip_source_ip <= hf_src;
        s_ip_dest_ip <= hf_dst;
        do @(posedge clk); while (!s_ip_hdr_ready);
        s_ip_hdr_valid <= 1'b0;
    endtask

    task automatic send_payload();
        int idx;
        bit vld;
        logic [63:0] d;
        logic [7:0] k;
        idx = 0;
        vld = 0;
        while (idx < pl.size() || vld) begin
            @(posedge clk);
            if (!vld || s_ip_payload_tready) begin
                if (idx < pl.size() && !(stress && ({$random(seed)} % 4) == 0)) begin
                    d = '0;
                    k = '0;
                    for (int i = 0; i < 8; i++) begin
                        if (idx + i < pl.size()) begin
                            d[8*i +: 8] = pl[idx + i];
                            k[i] = 1'b1;
                        end
                    end
                    s_ip_payload_tdata <= d;
                    s_ip_payload_tkeep <= k;
                    s_ip_payload_tlast <= (idx + 8 >= pl.size());
                    idx += 8;
                    vld = 1;
                end else begin
                    vld = 0;
                end
                s_ip_payload_tvalid <= vld;
            end
        end
    endtask

    // kind 0 exact, 1 longer than the length, 2 shorter
    task automatic run_frame(input int kind);
        int plen;
        int sent;
        plen = 2 + {$random(seed)} % 60;
        sent = plen;
        if (kind == 1) sent = plen + 1 + {$random(seed)} % 20;
        if (kind == 2) begin
            sent = 1 + {$random(seed)} % (plen - 1);
            short_frames++;
        end
        {hf_dmac, hf_smac} = {$random(seed), $random(seed), $random(seed)};
        {hf_type, hf_id, hf_src} = {$random(seed), $random(seed)};
        {hf_dscp, hf_ecn, hf_flags, hf_frag, hf_ttl, hf_proto} =
            40'({$random(seed), $random(seed)});
        hf_dst = $random(seed);
        build_frame(plen, sent, kind == 2);
        fork
            send_header();
            send_payload();
        join
    endtask

    initial begin
        #(NUM_FRAMES * MAX_WORDS * 20 * 8);
        $display("timeout: frames still outstanding after %0t", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed = 78654;
        rst = 1'b1;
        s_ip_hdr_valid = 1'b0;
        {s_eth_dest_mac, s_eth_src_mac, s_eth_type} = '0;
        {s_ip_dscp, s_ip_ecn, s_ip_length, s_ip_identification} = '0;
        {s_ip_flags, s_ip_fragment_offset, s_ip_ttl, s_ip_protocol} = '0;
        {s_ip_source_ip, s_ip_dest_ip} = '0;
        s_ip_payload_tdata = '0;
        s_ip_payload_tkeep = '0;
        s_ip_payload_tvalid = 1'b0;
        s_ip_payload_tlast = 1'b0;
        m_eth_hdr_ready = 1'b0;
        m_eth_payload_tready = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            // second half runs with back-pressure and input gaps
            stress = (f >= NUM_FRAMES / 2);
            run_frame(f % 3);
        end
        while (frames_done < NUM_FRAMES || eth_done < NUM_FRAMES) @(posedge clk);
        repeat (4) @(posedge clk);
        check_value("early termination pulses", err_pulses, short_frames);
        $display("frames %0d, headers %0d, errors %0d", frames_done, eth_done, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
rtl/ip_tx_pkg.sv
rtl/ip_hdr_capture.sv
rtl/ip_payload_align.sv
rtl/ip_tx_ctrl.sv
rtl/ip_skid_buffer.sv
rtl/ip_eth_tx.sv
verif/ip_eth_tx_tb.sv
